//--- hw/vector_pkg.sv
package vector_pkg;

    // Lane geometry
    localparam int SLICE_W       = 8;
    localparam int ELEM_W        = 16;
    localparam int ITER_W        = 3;
    localparam int VL_W          = 8;
    localparam int VREG_W        = 5;

    // Writeback buffering for ALU results held off by the multiplier
    localparam int WB_FIFO_DEPTH = 4;
    localparam int WB_PTR_W      = $clog2(WB_FIFO_DEPTH);

    typedef logic [ELEM_W-1:0]      elem_t;
    // Element i sits at slice[i]
    typedef elem_t [SLICE_W-1:0]    slice_t;
    typedef logic [SLICE_W-1:0]     mask_t;
    typedef logic [ITER_W-1:0]      iter_t;
    typedef logic [VL_W-1:0]        vl_t;
    typedef logic [VREG_W-1:0]      vsel_t;

    typedef enum logic [2:0] {
        VADD = 3'd0,
        VSUB = 3'd1,
        VAND = 3'd2,
        VOR  = 3'd3,
        VXOR = 3'd4,
        VMIN = 3'd5,
        VMAX = 3'd6,
        VMUL = 3'd7
    } opcode_t;

    // Single-element ALU result
    // VMUL never reaches the ALU, so it falls to zero here
    function automatic elem_t alu_compute(opcode_t op, elem_t a, elem_t b);
        elem_t res;
        case (op)
            VADD:    res = a + b;
            VSUB:    res = a - b;
            VAND:    res = a & b;
            VOR:     res = a | b;
            VXOR:    res = a ^ b;
            // Min and max compare as signed elements
            VMIN:    res = ($signed(a) < $signed(b)) ? a : b;
            VMAX:    res = ($signed(a) > $signed(b)) ? a : b;
            default: res = '0;
        endcase
        return res;
    endfunction

endpackage

//--- hw/lane_sequencer.sv
`timescale 1ns/1ps

module lane_sequencer import vector_pkg::*; (
    input  logic    CLK,
    input  logic    reset,
    // Issue strobe and slice
    input  logic    issue_valid,
    input  slice_t  v1,
    input  slice_t  v2,
    input  mask_t   vmask,
    input  logic    vm,
    input  logic    rm,
    input  opcode_t vop,
    input  vsel_t   vd,
    input  vl_t     vl,
    input  vl_t     base_idx,
    // Dispatch to the units
    output logic    busy,
    output logic    alu_valid,
    output logic    mul_valid,
    output elem_t   operand_a,
    output elem_t   operand_b,
    output opcode_t dispatch_op,
    output vsel_t   tag_vd,
    output iter_t   tag_iter,
    output logic    tag_last,
    output logic    tag_rm
);

    // Latched slice
    slice_t  v1_q;
    slice_t  v2_q;
    mask_t   active_q;
    iter_t   last_q;
    opcode_t op_q;
    vsel_t   vd_q;
    logic    rm_q;

    // Walk state
    iter_t   iter;
    logic    accept;
    logic    elem_active;

    // Active mask and highest active index of the incoming slice
    mask_t   active_d;
    iter_t   last_d;

    assign accept = issue_valid && !busy;

    always_comb begin : active_calc
        logic [VL_W:0] gidx;
        active_d = '0;
        last_d   = '0;
        for (int i = 0; i < SLICE_W; i++) begin
            // One extra bit so base_idx + i cannot wrap below vl
            gidx = {1'b0, base_idx} + (VL_W+1)'(i);
            // Inside the length AND enabled by the mask
            active_d[i] = (gidx < {1'b0, vl}) && (!vm || vmask[i]);
            if (active_d[i]) begin
                last_d = iter_t'(i);
            end
        end
    end

    // Busy and iteration counter
    always_ff @(posedge CLK) begin
        if (reset) begin
            busy <= 1'b0;
            iter <= '0;
        end else if (accept) begin
            busy <= 1'b1;
            iter <= '0;
        end else if (busy) begin
            iter <= iter + iter_t'(1);
            // Final element goes out this cycle
            if (iter == iter_t'(SLICE_W-1)) begin
                busy <= 1'b0;
            end
        end
    end

    // Slice payload, captured on accept
    always_ff @(posedge CLK) begin
        if (accept) begin
            v1_q     <= v1;
            v2_q     <= v2;
            active_q <= active_d;
            last_q   <= last_d;
            op_q     <= vop;
            vd_q     <= vd;
            rm_q     <= rm;
        end
    end

    // Inactive elements still take a cycle but raise no valid
    assign elem_active = busy && active_q[iter];
    assign alu_valid   = elem_active && (op_q != VMUL);
    assign mul_valid   = elem_active && (op_q == VMUL);

    // Current element and its tag
    assign operand_a   = v1_q[iter];
    assign operand_b   = v2_q[iter];
    assign dispatch_op = op_q;
    assign tag_vd      = vd_q;
    assign tag_iter    = iter;
    assign tag_last    = (iter == last_q);
    assign tag_rm      = rm_q;

endmodule

//--- hw/lane_alu.sv
`timescale 1ns/1ps

module lane_alu import vector_pkg::*; (
    input  logic    CLK,
    input  logic    reset,
    // From the sequencer
    input  logic    alu_valid,
    input  elem_t   operand_a,
    input  elem_t   operand_b,
    input  opcode_t dispatch_op,
    input  vsel_t   tag_vd,
    input  iter_t   tag_iter,
    input  logic    tag_last,
    input  logic    tag_rm,
    // To the writeback arbiter
    output logic    alu_done,
    output elem_t   alu_result,
    output vsel_t   alu_vd,
    output iter_t   alu_iter,
    output logic    alu_last,
    output logic    alu_rm
);

    elem_t result_d;

    // Combinational result of the current element
    assign result_d = alu_compute(dispatch_op, operand_a, operand_b);

    // Valid bit one cycle behind dispatch
    always_ff @(posedge CLK) begin
        if (reset) begin
            alu_done <= 1'b0;
        end else begin
            alu_done <= alu_valid;
        end
    end

    // Result and tag only move on a valid dispatch
    always_ff @(posedge CLK) begin
        if (alu_valid) begin
            alu_result <= result_d;
            alu_vd     <= tag_vd;
            alu_iter   <= tag_iter;
            alu_last   <= tag_last;
            alu_rm     <= tag_rm;
        end
    end

endmodule

//--- hw/lane_mul.sv
`timescale 1ns/1ps

module lane_mul import vector_pkg::*; (
    input  logic  CLK,
    input  logic  reset,
    // From the sequencer
    input  logic  mul_valid,
    input  elem_t operand_a,
    input  elem_t operand_b,
    input  vsel_t tag_vd,
    input  iter_t tag_iter,
    input  logic  tag_last,
    input  logic  tag_rm,
    // To the writeback arbiter
    output logic  mul_done,
    output elem_t mul_result,
    output vsel_t mul_vd,
    output iter_t mul_iter,
    output logic  mul_last,
    output logic  mul_rm
);

    // Stage 1, operand capture
    logic  s1_valid;
    elem_t s1_a;
    elem_t s1_b;
    vsel_t s1_vd;
    iter_t s1_iter;
    logic  s1_last;
    logic  s1_rm;

    // Stage 2, product register
    logic  s2_valid;
    elem_t s2_prod;
    vsel_t s2_vd;
    iter_t s2_iter;
    logic  s2_last;
    logic  s2_rm;

    // Valid shift chain
    always_ff @(posedge CLK) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            mul_done <= 1'b0;
        end else begin
            s1_valid <= mul_valid;
            s2_valid <= s1_valid;
            mul_done <= s2_valid;
        end
    end

    // Data path advances every cycle, so one product can enter per cycle
    always_ff @(posedge CLK) begin
        s1_a       <= operand_a;
        s1_b       <= operand_b;
        s1_vd      <= tag_vd;
        s1_iter    <= tag_iter;
        s1_last    <= tag_last;
        s1_rm      <= tag_rm;
        // Only the low ELEM_W bits of the product are kept
        s2_prod    <= elem_t'(s1_a * s1_b);
        s2_vd      <= s1_vd;
        s2_iter    <= s1_iter;
        s2_last    <= s1_last;
        s2_rm      <= s1_rm;
        mul_result <= s2_prod;
        mul_vd     <= s2_vd;
        mul_iter   <= s2_iter;
        mul_last   <= s2_last;
        mul_rm     <= s2_rm;
    end

endmodule

//--- hw/lane_wb_arbiter.sv
`timescale 1ns/1ps

module lane_wb_arbiter import vector_pkg::*; (
    input  logic  CLK,
    input  logic  reset,
    // ALU results
    input  logic  alu_done,
    input  elem_t alu_result,
    input  vsel_t alu_vd,
    input  iter_t alu_iter,
    input  logic  alu_last,
    input  logic  alu_rm,
    // Multiplier results
    input  logic  mul_done,
    input  elem_t mul_result,
    input  vsel_t mul_vd,
    input  iter_t mul_iter,
    input  logic  mul_last,
    input  logic  mul_rm,
    // Writeback port
    output logic  wb_valid,
    output vsel_t wb_vd,
    output iter_t wb_iter,
    output elem_t wb_data,
    output logic  wb_last,
    output logic  wb_rm
);

    typedef struct packed {
        elem_t data;
        vsel_t vd;
        iter_t iter;
        logic  last;
        logic  rm;
    } wb_entry_t;

    wb_entry_t                alu_entry;
    wb_entry_t                mul_entry;
    wb_entry_t                head;
    wb_entry_t                fifo_mem [WB_FIFO_DEPTH];
    logic [WB_PTR_W-1:0]      wr_ptr;
    logic [WB_PTR_W-1:0]      rd_ptr;
    logic [WB_PTR_W:0]        count;
    logic                     empty;
    logic                     bypass;
    logic                     push;
    logic                     pop;

    assign alu_entry = '{alu_result, alu_vd, alu_iter, alu_last, alu_rm};
    assign mul_entry = '{mul_result, mul_vd, mul_iter, mul_last, mul_rm};

    assign empty  = (count == '0);
    // Empty FIFO and free port, ALU result goes straight out
    assign bypass = alu_done && empty && !mul_done;
    assign push   = alu_done && !bypass;
    // Multiplier wins the port, queued ALU results drain otherwise
    assign pop    = !empty && !mul_done;
    assign head   = fifo_mem[rd_ptr];

    // FIFO pointers and occupancy
    always_ff @(posedge CLK) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (WB_PTR_W+1)'(push) - (WB_PTR_W+1)'(pop);
        end
    end

    always_ff @(posedge CLK) begin
        if (push) begin
            fifo_mem[wr_ptr] <= alu_entry;
        end
    end

    // Registered writeback
    always_ff @(posedge CLK) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= mul_done || pop || bypass;
        end
    end

    always_ff @(posedge CLK) begin
        if (mul_done) begin
            {wb_data, wb_vd, wb_iter, wb_last, wb_rm} <= mul_entry;
        end else if (pop) begin
            {wb_data, wb_vd, wb_iter, wb_last, wb_rm} <= head;
        end else if (bypass) begin
            {wb_data, wb_vd, wb_iter, wb_last, wb_rm} <= alu_entry;
        end
    end

endmodule

//--- hw/lane_reduce.sv
`timescale 1ns/1ps

module lane_reduce import vector_pkg::*; (
    input  logic  CLK,
    input  logic  reset,
    // Writeback stream
    input  logic  wb_valid,
    input  elem_t wb_data,
    input  logic  wb_last,
    input  logic  wb_rm,
    // Reduction result
    output logic  reduction_valid,
    output elem_t reduction
);

    elem_t acc;
    elem_t sum;
    logic  take;
    logic  finish;

    // Only writebacks of reduction instructions count
    assign take   = wb_valid && wb_rm;
    assign finish = take && wb_last;
    // Wraps modulo 2^ELEM_W
    assign sum    = acc + wb_data;

    // Running sum, cleared once the last element is folded in
    always_ff @(posedge CLK) begin
        if (reset) begin
            acc             <= '0;
            reduction_valid <= 1'b0;
        end else begin
            reduction_valid <= finish;
            if (finish) begin
                acc <= '0;
            end else if (take) begin
                acc <= sum;
            end
        end
    end

    // Total held until the next reduction finishes
    always_ff @(posedge CLK) begin
        if (finish) begin
            reduction <= sum;
        end
    end

endmodule

//--- hw/lane.sv
`timescale 1ns/1ps

module lane import vector_pkg::*; (
    input  logic    CLK,
    input  logic    reset,
    // Issue
    input  logic    issue_valid,
    input  slice_t  v1,
    input  slice_t  v2,
    input  mask_t   vmask,
    input  logic    vm,
    input  logic    rm,
    input  opcode_t vop,
    input  vsel_t   vd,
    input  vl_t     vl,
    input  vl_t     base_idx,
    // Status and results
    output logic    busy,
    output logic    wb_valid,
    output vsel_t   wb_vd,
    output iter_t   wb_iter,
    output elem_t   wb_data,
    output logic    reduction_valid,
    output elem_t   reduction
);

    // Sequencer to units
    logic    alu_valid;
    logic    mul_valid;
    elem_t   operand_a;
    elem_t   operand_b;
    opcode_t dispatch_op;
    vsel_t   tag_vd;
    iter_t   tag_iter;
    logic    tag_last;
    logic    tag_rm;

    // ALU to arbiter
    logic    alu_done;
    elem_t   alu_result;
    vsel_t   alu_vd;
    iter_t   alu_iter;
    logic    alu_last;
    logic    alu_rm;

    // Multiplier to arbiter
    logic    mul_done;
    elem_t   mul_result;
    vsel_t   mul_vd;
    iter_t   mul_iter;
    logic    mul_last;
    logic    mul_rm;

    // Writeback sideband into the reduction unit
    logic    wb_last;
    logic    wb_rm;

    lane_sequencer seq0 (.*);

    lane_alu alu0 (.*);

    lane_mul mul0 (.*);

    lane_wb_arbiter arb0 (.*);

    lane_reduce red0 (.*);

endmodule

//--- bench/lane_tb.sv
`timescale 1ns/1ps

module lane_tb import vector_pkg::*; ();

    // Cycles any single wait may take before giving up
    localparam int WAIT_LIMIT = 100;

    logic    CLK;
    logic    reset;
    logic    issue_valid;
    slice_t  v1;
    slice_t  v2;
    mask_t   vmask;
    logic    vm;
    logic    rm;
    opcode_t vop;
    vsel_t   vd;
    vl_t     vl;
    vl_t     base_idx;
    logic    busy;
    logic    wb_valid;
    vsel_t   wb_vd;
    iter_t   wb_iter;
    elem_t   wb_data;
    logic    reduction_valid;
    elem_t   reduction;

    // One expected writeback
    typedef struct packed {
        vsel_t vd;
        iter_t iter;
        elem_t data;
        logic  last;
        logic  rm;
    } wb_exp_t;

    wb_exp_t exp_q [$];
    // Expected reduction total per destination register
    elem_t   red_sum [1<<VREG_W];
    logic    red_pending;
    elem_t   red_expect;
    int      errors;
    int      tests_ok;
    int      tests_bad;
    logic    timed_out;
    vsel_t   next_vd;

    lane dut0 (.*);

    always #5 CLK = ~CLK;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected);
        end
    endtask

    // Reference element result, written from the opcode definitions
    function automatic elem_t expected_elem(opcode_t op, elem_t a, elem_t b);
        logic [2*ELEM_W-1:0] prod;
        prod = {{ELEM_W{1'b0}}, a} * {{ELEM_W{1'b0}}, b};
        case (op)
            VADD:    return a + b;
            VSUB:    return a - b;
            VAND:    return a & b;
            VOR:     return a | b;
            VXOR:    return a ^ b;
            VMIN:    return ($signed(a) <= $signed(b)) ? a : b;
            VMAX:    return ($signed(a) >= $signed(b)) ? a : b;
            VMUL:    return prod[ELEM_W-1:0];
            default: return '0;
        endcase
    endfunction

    task automatic wait_not_busy();
        int n;
        n = 0;
        while (busy && n < WAIT_LIMIT) begin
            @(posedge CLK);
            #1;
            n++;
        end
        if (busy) begin
            timed_out = 1'b1;
            errors++;
            $display("Timeout: lane stayed busy for %0d cycles", WAIT_LIMIT);
        end
    endtask

    // Random operands, expectations queued in element order
    task automatic issue_slice(input opcode_t op, input logic rm_i, input logic vm_i,
                               input mask_t mask_i, input vl_t vl_i, input vl_t base_i);
        mask_t act;
        int    last_i;
        elem_t r;
        wait_not_busy();
        if (timed_out) begin
            return;
        end
        for (int i = 0; i < SLICE_W; i++) begin
            v1[i] = elem_t'($urandom);
            v2[i] = elem_t'($urandom);
        end
        vop      = op;
        rm       = rm_i;
        vm       = vm_i;
        vmask    = mask_i;
        vl       = vl_i;
        base_idx = base_i;
        vd       = next_vd;
        // Active only inside the length and enabled by the mask
        act    = '0;
        last_i = -1;
        for (int i = 0; i < SLICE_W; i++) begin
            act[i] = ((int'(base_i) + i) < int'(vl_i)) && (!vm_i || mask_i[i]);
            if (act[i]) begin
                last_i = i;
            end
        end
        red_sum[next_vd] = '0;
        for (int i = 0; i < SLICE_W; i++) begin
            if (act[i]) begin
                r = expected_elem(op, v1[i], v2[i]);
                red_sum[next_vd] = red_sum[next_vd] + r;
                exp_q.push_back('{next_vd, iter_t'(i), r, i == last_i, rm_i});
            end
        end
        issue_valid = 1'b1;
        @(posedge CLK);
        #1;
        issue_valid = 1'b0;
        // Fresh register per instruction keeps in-flight results apart
        next_vd++;
    endtask

    // Writeback and reduction monitor, sampled mid-cycle
    always @(negedge CLK) begin : monitor
        int      idx;
        wb_exp_t e;
        if (!reset) begin
            if (red_pending) begin
                check_value("reduction_valid", reduction_valid, 1);
                check_value("reduction", reduction, red_expect);
                red_pending = 1'b0;
            end else if (reduction_valid) begin
                errors++;
                $display("Reduction pulse with no reduction instruction finishing");
            end
            if (wb_valid) begin
                // Oldest outstanding result for this register
                idx = -1;
                for (int k = 0; k < exp_q.size(); k++) begin
                    if (idx < 0 && exp_q[k].vd == wb_vd) begin
                        idx = k;
                    end
                end
                if (idx < 0) begin
                    errors++;
                    $display("Writeback on v%0d when no result was expected", wb_vd);
                end else begin
                    e = exp_q[idx];
                    exp_q.delete(idx);
                    check_value("wb_iter", wb_iter, e.iter);
                    check_value("wb_data", wb_data, e.data);
                    if (e.last && e.rm) begin
                        red_pending = 1'b1;
                        red_expect  = red_sum[e.vd];
                    end
                end
            end
        end
    end

    task automatic drain();
        int n;
        if (timed_out) begin
            return;
        end
        n = 0;
        while ((busy || exp_q.size() != 0 || red_pending) && n < WAIT_LIMIT) begin
            @(posedge CLK);
            #1;
            n++;
        end
        if (busy || exp_q.size() != 0 || red_pending) begin
            timed_out = 1'b1;
            errors++;
            $display("Timeout: %0d writebacks never arrived", exp_q.size());
        end
        // A few idle cycles to catch stray writebacks
        repeat (4) @(posedge CLK);
        #1;
    endtask

    task automatic finish_test(input string name, input int start_errors);
        drain();
        if (errors == start_errors) begin
            tests_ok++;
            $display("%-12s ok", name);
        end else begin
            tests_bad++;
            $display("%-12s %0d errors", name, errors - start_errors);
        end
    endtask

    initial begin
        int s;
        CLK         = 1'b0;
        reset       = 1'b1;
        issue_valid = 1'b0;
        v1          = '0;
        v2          = '0;
        vmask       = '0;
        vm          = 1'b0;
        rm          = 1'b0;
        vop         = VADD;
        vd          = '0;
        vl          = '0;
        base_idx    = '0;
        red_pending = 1'b0;
        red_expect  = '0;
        errors      = 0;
        tests_ok    = 0;
        tests_bad   = 0;
        timed_out   = 1'b0;
        next_vd     = '0;
        void'($urandom(32'hb7ae_39f5));
        repeat (2) @(posedge CLK);
        #1;
        reset = 1'b0;

        // Idle after reset
        s = errors;
        repeat (5) begin
            @(negedge CLK);
            check_value("busy", busy, 0);
            check_value("wb_valid", wb_valid, 0);
            check_value("reduction_valid", reduction_valid, 0);
        end
        @(posedge CLK);
        #1;
        finish_test("reset", s);

        // Every ALU opcode, full slice
        s = errors;
        for (int o = 0; o < 7; o++) begin
            repeat (2) issue_slice(opcode_t'(o), 0, 0, '0, vl_t'(SLICE_W), '0);
        end
        finish_test("alu_ops", s);

        s = errors;
        repeat (4) issue_slice(VMUL, 0, 0, '0, vl_t'(SLICE_W), '0);
        finish_test("multiply", s);

        // Partial lengths, offsets and masks
        s = errors;
        repeat (24) begin
            issue_slice(opcode_t'($urandom_range(7, 0)), 1'($urandom_range(1, 0)),
                        1'($urandom_range(1, 0)), mask_t'($urandom),
                        vl_t'($urandom_range(24, 0)), vl_t'($urandom_range(16, 0)));
        end
        finish_test("len_mask", s);

        // Multiplier results contend with the following ALU slice
        s = errors;
        repeat (6) begin
            issue_slice(VMUL, 1'($urandom_range(1, 0)), 0, '0, vl_t'(SLICE_W), '0);
            issue_slice(opcode_t'($urandom_range(6, 0)), 1'($urandom_range(1, 0)), 0, '0,
                        vl_t'(SLICE_W), '0);
        end
        finish_test("mixed", s);

        s = errors;
        repeat (10) begin
            issue_slice(opcode_t'($urandom_range(7, 0)), 1, 1'($urandom_range(1, 0)),
                        mask_t'($urandom), vl_t'($urandom_range(16, 0)),
                        vl_t'($urandom_range(8, 0)));
        end
        // No active elements, so no pulse
        issue_slice(VADD, 1, 0, '1, '0, '0);
        issue_slice(VMUL, 1, 1, '0, vl_t'(SLICE_W), '0);
        issue_slice(VXOR, 1, 0, '0, vl_t'(SLICE_W), vl_t'(SLICE_W));
        finish_test("reduction", s);

        $display("tests ok %0d, tests with errors %0d, total errors %0d",
                 tests_ok, tests_bad, errors);
        if (errors == 0 && !timed_out) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- flist.f
hw/vector_pkg.sv
hw/lane_sequencer.sv
hw/lane_alu.sv
hw/lane_mul.sv
hw/lane_wb_arbiter.sv
hw/lane_reduce.sv
hw/lane.sv
bench/lane_tb.sv

//--- Bender.yml
package:
  name: vector_lane

sources:
  - hw/vector_pkg.sv
  - hw/lane_sequencer.sv
  - hw/lane_alu.sv
  - hw/lane_mul.sv
  - hw/lane_wb_arbiter.sv
  - hw/lane_reduce.sv
  - hw/lane.sv
  - target: simulation
    files:
      - bench/lane_tb.sv
